/* rtl/soc_bus_pkg.sv */
package soc_bus_pkg;

    // Data bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;
    localparam int DEV_W  = 8;

    typedef logic [ADDR_W-1:0] bus_addr_t;
    typedef logic [DATA_W-1:0] bus_data_t;
    typedef logic [SEL_W-1:0]  bus_sel_t;

    // Device field, address bits 31 to 24
    typedef logic [DEV_W-1:0]  dev_id_t;

    // Device address map
    localparam dev_id_t GPIO_ADDR  = 8'h40;
    localparam dev_id_t UART_ADDR  = 8'h50;
    localparam dev_id_t IRQ_ADDR   = 8'h80;
    localparam dev_id_t TIMER_ADDR = 8'hc0;

endpackage

/* rtl/soc_periph_pkg.sv */
package soc_periph_pkg;

    // Word aligned offset, address bits 3 to 0
    typedef logic [3:0] reg_off_t;

    // RISC-V machine timer value
    typedef logic [63:0] mtime_t;

    // UART transmit sequencing
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

    // Timer registers
    localparam reg_off_t MTIME_LO    = 4'h0;
    localparam reg_off_t MTIME_HI    = 4'h4;
    localparam reg_off_t MTIMECMP_LO = 4'h8;
    localparam reg_off_t MTIMECMP_HI = 4'hc;

    // UART registers
    localparam reg_off_t UART_DATA   = 4'h0;
    localparam reg_off_t UART_STATUS = 4'h4;

    // Interrupt registers
    localparam reg_off_t IRQ_PENDING = 4'h0;
    localparam reg_off_t IRQ_ENABLE  = 4'h4;

endpackage

/* rtl/dbus_decode.sv */
`timescale 1ns/1ps

module dbus_decode (
    input  logic                  ck,
    input  logic                  RESET_LOOP,
    input  logic                  i_cyc,
    input  soc_bus_pkg::bus_addr_t i_adr,
    input  soc_bus_pkg::bus_data_t i_gpio_rdt,
    input  soc_bus_pkg::bus_data_t i_uart_rdt,
    input  soc_bus_pkg::bus_data_t i_irq_rdt,
    input  soc_bus_pkg::bus_data_t i_tim_rdt,
    output logic                  o_gpio_stb,
    output logic                  o_uart_stb,
    output logic                  o_irq_stb,
    output logic                  o_tim_stb,
    output logic                  o_ack,
    output soc_bus_pkg::bus_data_t o_rdt
);
    import soc_bus_pkg::*;

    dev_id_t    dev;
    logic       cyc_q;
    logic       first;
    logic [3:0] hit;
    logic [3:0] dev_q;

    assign dev   = i_adr[ADDR_W-1 -: DEV_W];
    assign first = i_cyc & ~cyc_q;

    // One bit per device: gpio, uart, irq, timer
    assign hit[0] = (dev == GPIO_ADDR);
    assign hit[1] = (dev == UART_ADDR);
    assign hit[2] = (dev == IRQ_ADDR);
    assign hit[3] = (dev == TIMER_ADDR);

    assign o_gpio_stb = first & hit[0];
    assign o_uart_stb = first & hit[1];
    assign o_irq_stb  = first & hit[2];
    assign o_tim_stb  = first & hit[3];

    // Unmapped devices are acked too, so the bus cannot hang
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            cyc_q <= 1'b0;
            o_ack <= 1'b0;
            dev_q <= '0;
        end else begin
            cyc_q <= i_cyc;
            o_ack <= first;
            if (first) begin
                dev_q <= hit;
            end
        end
    end

    // Read word of the device that was strobed, zero outside ack
    always_comb begin
        o_rdt = '0;
        if (o_ack) begin
            o_rdt = ({DATA_W{dev_q[0]}} & i_gpio_rdt)
                  | ({DATA_W{dev_q[1]}} & i_uart_rdt)
                  | ({DATA_W{dev_q[2]}} & i_irq_rdt)
                  | ({DATA_W{dev_q[3]}} & i_tim_rdt);
        end
    end

    a_ack_single: assert property (@(posedge ck) disable iff (RESET_LOOP)
        o_ack |=> !o_ack);

    a_one_stb: assert property (@(posedge ck) disable iff (RESET_LOOP)
        $onehot0({o_tim_stb, o_irq_stb, o_uart_stb, o_gpio_stb}));

endmodule

/* rtl/gpio_reg.sv */
`timescale 1ns/1ps

module gpio_reg (
    input  logic                  ck,
    input  logic                  RESET_LOOP,
    input  logic                  i_stb,
    input  logic                  i_we,
    input  soc_bus_pkg::bus_sel_t  i_sel,
    input  soc_bus_pkg::bus_data_t i_dat,
    output soc_bus_pkg::bus_data_t o_rdt,
    output logic [7:0]            o_gpio
);
    import soc_bus_pkg::*;

    // Port register, loaded through byte lane 0 only
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            o_gpio <= '0;
        end else if (i_stb && i_we && i_sel[0]) begin
            o_gpio <= i_dat[7:0];
        end
    end

    // Read back of the current port value
    always_ff @(posedge ck) begin
        if (i_stb && !i_we) begin
            o_rdt <= bus_data_t'(o_gpio);
        end
    end

endmodule

/* rtl/mtimer.sv */
`timescale 1ns/1ps

module mtimer (
    input  logic                    ck,
    input  logic                    RESET_LOOP,
    input  logic                    i_stb,
    input  logic                    i_we,
    input  soc_periph_pkg::reg_off_t i_off,
    input  soc_bus_pkg::bus_data_t   i_dat,
    output soc_bus_pkg::bus_data_t   o_rdt,
    output logic                    o_irq
);
    import soc_periph_pkg::*;

    mtime_t mtime;
    mtime_t mtimecmp;
    logic   wr;

    assign wr = i_stb & i_we;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            mtime    <= '0;
            mtimecmp <= '1;
            o_irq    <= 1'b0;
        end else begin
            // A half written by the bus skips the count for that cycle
            if (wr && i_off == MTIME_LO) begin
                mtime[31:0] <= i_dat;
            end else if (wr && i_off == MTIME_HI) begin
                mtime[63:32] <= i_dat;
            end else begin
                mtime <= mtime + 1'b1;
            end

            if (wr && i_off == MTIMECMP_LO) begin
                mtimecmp[31:0] <= i_dat;
            end
            if (wr && i_off == MTIMECMP_HI) begin
                mtimecmp[63:32] <= i_dat;
            end

            o_irq <= (mtime >= mtimecmp);
        end
    end

    // Read word captured on the strobe edge
    always_ff @(posedge ck) begin
        if (i_stb && !i_we) begin
            case (i_off)
                MTIME_LO:    o_rdt <= mtime[31:0];
                MTIME_HI:    o_rdt <= mtime[63:32];
                MTIMECMP_LO: o_rdt <= mtimecmp[31:0];
                MTIMECMP_HI: o_rdt <= mtimecmp[63:32];
                default:     o_rdt <= '0;
            endcase
        end
    end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int BAUD_DIV = 16
) (
    input  logic                    ck,
    input  logic                    RESET_LOOP,
    input  logic                    i_stb,
    input  logic                    i_we,
    input  soc_periph_pkg::reg_off_t i_off,
    input  soc_bus_pkg::bus_data_t   i_dat,
    output soc_bus_pkg::bus_data_t   o_rdt,
    output logic                    o_tx,
    output logic                    o_done
);
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    uart_state_e      state;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             bit_end;
    logic             busy;
    logic             load;

    assign bit_end = (baud_cnt == CNT_W'(BAUD_DIV - 1));
    assign busy    = (state != IDLE);
    // Writes while a frame is running are dropped
    assign load    = i_stb & i_we & (i_off == UART_DATA) & ~busy;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (state != IDLE) begin
                baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (load) begin
                        state    <= START;
                        baud_cnt <= '0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state   <= DATA;
                        bit_idx <= '0;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state  <= IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge ck) begin
        if (load) begin
            shift <= i_dat[7:0];
        end else if (state == DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

    // Line follows the state one cycle later
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            o_tx <= 1'b1;
        end else begin
            case (state)
                START:   o_tx <= 1'b0;
                DATA:    o_tx <= shift[0];
                default: o_tx <= 1'b1;
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (i_stb && !i_we) begin
            o_rdt <= (i_off == UART_STATUS) ? bus_data_t'(busy) : '0;
        end
    end

    a_start_from_idle: assert property (@(posedge ck) disable iff (RESET_LOOP)
        $rose(state == START) |-> $past(state) == IDLE);

endmodule

/* rtl/irq_reg.sv */
`timescale 1ns/1ps

module irq_reg #(
    parameter int IRQ_WIDTH = 2
) (
    input  logic                    ck,
    input  logic                    RESET_LOOP,
    input  logic                    i_stb,
    input  logic                    i_we,
    input  soc_periph_pkg::reg_off_t i_off,
    input  soc_bus_pkg::bus_data_t   i_dat,
    input  logic [IRQ_WIDTH-1:0]    i_src,
    output soc_bus_pkg::bus_data_t   o_rdt,
    output logic                    o_irq
);
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    logic [IRQ_WIDTH-1:0] pending;
    logic [IRQ_WIDTH-1:0] enable;
    logic [IRQ_WIDTH-1:0] clr;

    // Write one to clear
    assign clr = (i_stb && i_we && i_off == IRQ_PENDING) ? i_dat[IRQ_WIDTH-1:0] : '0;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            pending <= '0;
            enable  <= '0;
            o_irq   <= 1'b0;
        end else begin
            // Clear wins, a source still high sets the bit again next cycle
            pending <= (pending | i_src) & ~clr;
            if (i_stb && i_we && i_off == IRQ_ENABLE) begin
                enable <= i_dat[IRQ_WIDTH-1:0];
            end
            o_irq <= |(pending & enable);
        end
    end

    always_ff @(posedge ck) begin
        if (i_stb && !i_we) begin
            case (i_off)
                IRQ_PENDING: o_rdt <= bus_data_t'(pending);
                IRQ_ENABLE:  o_rdt <= bus_data_t'(enable);
                default:     o_rdt <= '0;
            endcase
        end
    end

    a_irq_cause: assert property (@(posedge ck) disable iff (RESET_LOOP)
        o_irq |-> $past(|(pending & enable)));

endmodule

/* rtl/periph_top.sv */
`timescale 1ns/1ps

module periph_top #(
    parameter int BAUD_DIV  = 16,
    parameter int IRQ_WIDTH = 2
) (
    input  logic                  ck,
    input  logic                  RESET_LOOP,
    input  logic                  i_cyc,
    input  logic                  i_we,
    input  soc_bus_pkg::bus_sel_t  i_sel,
    input  soc_bus_pkg::bus_addr_t i_adr,
    input  soc_bus_pkg::bus_data_t i_dat,
    output soc_bus_pkg::bus_data_t o_rdt,
    output logic                  o_ack,
    output logic [7:0]            o_gpio,
    output logic                  o_tx,
    output logic                  o_irq
);
    import soc_bus_pkg::*;

    logic      gpio_stb;
    logic      uart_stb;
    logic      irq_stb;
    logic      tim_stb;
    bus_data_t gpio_rdt;
    bus_data_t uart_rdt;
    bus_data_t irq_rdt;
    bus_data_t tim_rdt;
    logic      tim_irq;
    logic      uart_done;

    dbus_decode u_decode (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_cyc      (i_cyc),
        .i_adr      (i_adr),
        .i_gpio_rdt (gpio_rdt),
        .i_uart_rdt (uart_rdt),
        .i_irq_rdt  (irq_rdt),
        .i_tim_rdt  (tim_rdt),
        .o_gpio_stb (gpio_stb),
        .o_uart_stb (uart_stb),
        .o_irq_stb  (irq_stb),
        .o_tim_stb  (tim_stb),
        .o_ack      (o_ack),
        .o_rdt      (o_rdt)
    );

    gpio_reg u_gpio (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_stb      (gpio_stb),
        .i_we       (i_we),
        .i_sel      (i_sel),
        .i_dat      (i_dat),
        .o_rdt      (gpio_rdt),
        .o_gpio     (o_gpio)
    );

    mtimer u_timer (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_stb      (tim_stb),
        .i_we       (i_we),
        .i_off      (i_adr[3:0]),
        .i_dat      (i_dat),
        .o_rdt      (tim_rdt),
        .o_irq      (tim_irq)
    );

    uart_tx #(.BAUD_DIV(BAUD_DIV)) u_uart (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_stb      (uart_stb),
        .i_we       (i_we),
        .i_off      (i_adr[3:0]),
        .i_dat      (i_dat),
        .o_rdt      (uart_rdt),
        .o_tx       (o_tx),
        .o_done     (uart_done)
    );

    // Bit 0 timer, bit 1 UART frame done
    irq_reg #(.IRQ_WIDTH(IRQ_WIDTH)) u_irq (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_stb      (irq_stb),
        .i_we       (i_we),
        .i_off      (i_adr[3:0]),
        .i_dat      (i_dat),
        .i_src      ({uart_done, tim_irq}),
        .o_rdt      (irq_rdt),
        .o_irq      (o_irq)
    );

endmodule

/* tb/tb_periph_top.sv */
`timescale 1ns/1ps

module tb_periph_top;
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    localparam int BAUD_DIV   = 4;
    localparam int ACK_LIMIT  = 16;
    localparam int WAIT_LIMIT = 80;

    logic      ck = 1'b0;
    logic      RESET_LOOP;
    logic      i_cyc;
    logic      i_we;
    bus_sel_t  i_sel;
    bus_addr_t i_adr;
    bus_data_t i_dat;
    bus_data_t o_rdt;
    logic      o_ack;
    logic [7:0] o_gpio;
    logic      o_tx;
    logic      o_irq;

    // Test table, one entry per bus transfer
    string     t_name[$];
    logic      t_we[$];
    bus_addr_t t_adr[$];
    bus_data_t t_dat[$];
    bus_sel_t  t_sel[$];
    logic      t_cmp[$];
    bus_data_t t_exp[$];

    logic [31:0] rng = 32'h662347c3;

    periph_top #(.BAUD_DIV(BAUD_DIV), .IRQ_WIDTH(2)) u_dut (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_cyc      (i_cyc),
        .i_we       (i_we),
        .i_sel      (i_sel),
        .i_adr      (i_adr),
        .i_dat      (i_dat),
        .o_rdt      (o_rdt),
        .o_ack      (o_ack),
        .o_gpio     (o_gpio),
        .o_tx       (o_tx),
        .o_irq      (o_irq)
    );

    always #20 ck = ~ck;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bus_addr_t dev_addr(input dev_id_t dev, input reg_off_t off);
        return {dev, 20'h0, off};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check(input string name, input bus_data_t exp, input bus_data_t act);
        if (exp !== act) begin
            abort_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // One bus transfer, driven on the falling edge
    task automatic bus_xfer(input logic we, input bus_addr_t adr, input bus_data_t dat,
                            input bus_sel_t sel, output bus_data_t rdata);
        int n;
        @(negedge ck);
        i_cyc = 1'b1;
        i_we  = we;
        i_adr = adr;
        i_dat = dat;
        i_sel = sel;
        n = 0;
        @(negedge ck);
        while (!o_ack && n < ACK_LIMIT) begin
            @(negedge ck);
            n++;
        end
        if (!o_ack) begin
            abort_run($sformatf("Bus hang: no ack for address %h", adr));
        end
        rdata = o_rdt;
        i_cyc = 1'b0;
        i_we  = 1'b0;
        @(negedge ck);
        check("ack single cycle", 32'h0, o_ack);
    endtask

    task automatic add_step(input string name, input logic we, input bus_addr_t adr,
                            input bus_data_t dat, input bus_sel_t sel, input logic cmp,
                            input bus_data_t exp);
        t_name.push_back(name);
        t_we.push_back(we);
        t_adr.push_back(adr);
        t_dat.push_back(dat);
        t_sel.push_back(sel);
        t_cmp.push_back(cmp);
        t_exp.push_back(exp);
    endtask

    // Apply every queued entry, then empty the table
    task automatic run_table();
        bus_data_t rd;
        for (int i = 0; i < t_name.size(); i++) begin
            bus_xfer(t_we[i], t_adr[i], t_dat[i], t_sel[i], rd);
            if (t_cmp[i]) begin
                check(t_name[i], t_exp[i], rd);
            end
        end
        t_name.delete();
        t_we.delete();
        t_adr.delete();
        t_dat.delete();
        t_sel.delete();
        t_cmp.delete();
        t_exp.delete();
    endtask

    // Samples each bit near its middle, 8N1
    task automatic uart_monitor(output logic [7:0] rx_byte, output logic stop_bit);
        uart_state_e mon;
        int n;
        int b;
        logic done;
        mon = IDLE;
        n = 0;
        b = 0;
        done = 1'b0;
        rx_byte = '0;
        stop_bit = 1'b0;
        while (!done) begin
            case (mon)
                IDLE: begin
                    // Line idles high until the start edge
                    if (!o_tx) begin
                        mon = START;
                    end else if (n < WAIT_LIMIT) begin
                        @(negedge ck);
                        n++;
                    end else begin
                        abort_run("UART start bit never appeared on o_tx");
                    end
                end
                START: begin
                    @(negedge ck);
                    check("uart start bit", 32'h0, o_tx);
                    mon = DATA;
                end
                DATA: begin
                    repeat (BAUD_DIV) @(negedge ck);
                    rx_byte[b] = o_tx;
                    b++;
                    if (b == 8) begin
                        mon = STOP;
                    end
                end
                STOP: begin
                    repeat (BAUD_DIV) @(negedge ck);
                    stop_bit = o_tx;
                    mon = IDLE;
                    done = 1'b1;
                end
            endcase
        end
    endtask

    initial begin
        bus_data_t rd;
        bus_data_t t0;
        bus_data_t t1;
        logic [7:0] val;
        logic [7:0] rx_byte;
        logic stop_bit;
        int n;

        RESET_LOOP = 1'b1;
        i_cyc = 1'b0;
        i_we  = 1'b0;
        i_sel = '0;
        i_adr = '0;
        i_dat = '0;
        repeat (16) @(posedge ck);
        @(negedge ck);
        RESET_LOOP = 1'b0;

        // GPIO with random bytes
        for (int i = 0; i < 4; i++) begin
            rng = lcg_next(rng);
            val = rng[7:0];
            add_step("gpio write", 1'b1, dev_addr(GPIO_ADDR, 4'h0), rng, 4'hf, 1'b0, 32'h0);
            add_step("gpio read", 1'b0, dev_addr(GPIO_ADDR, 4'h0), 32'h0, 4'hf, 1'b1, {24'h0, val});
            run_table();
            check("gpio port", {24'h0, val}, o_gpio);
        end
        add_step("gpio lane0 off", 1'b1, dev_addr(GPIO_ADDR, 4'h0), {24'h0, ~val}, 4'he,
                 1'b0, 32'h0);
        add_step("gpio unchanged", 1'b0, dev_addr(GPIO_ADDR, 4'h0), 32'h0, 4'hf, 1'b1,
                 {24'h0, val});
        // Unmapped device 0x33
        add_step("unmapped write", 1'b1, 32'h3300_0004, 32'hdead_beef, 4'hf, 1'b0, 32'h0);
        add_step("unmapped read", 1'b0, 32'h3300_0004, 32'h0, 4'hf, 1'b1, 32'h0);
        run_table();
        check("gpio port kept", {24'h0, val}, o_gpio);

        // UART frame with the monitor running alongside the bus
        fork
            uart_monitor(rx_byte, stop_bit);
            begin
                add_step("uart write", 1'b1, dev_addr(UART_ADDR, UART_DATA), 32'h5a, 4'hf,
                         1'b0, 32'h0);
                add_step("uart busy", 1'b0, dev_addr(UART_ADDR, UART_STATUS), 32'h0, 4'hf,
                         1'b1, 32'h1);
                add_step("uart busy write", 1'b1, dev_addr(UART_ADDR, UART_DATA), 32'hc3,
                         4'hf, 1'b0, 32'h0);
                run_table();
            end
        join
        check("uart byte", 32'h5a, {24'h0, rx_byte});
        check("uart stop bit", 32'h1, stop_bit);
        n = 0;
        rd = 32'h1;
        while (rd[0] && n < 10) begin
            bus_xfer(1'b0, dev_addr(UART_ADDR, UART_STATUS), 32'h0, 4'hf, rd);
            n++;
        end
        check("uart idle", 32'h0, rd);

        // Interrupt register after the frame
        add_step("irq pending uart", 1'b0, dev_addr(IRQ_ADDR, IRQ_PENDING), 32'h0, 4'hf,
                 1'b1, 32'h2);
        add_step("irq enable timer", 1'b1, dev_addr(IRQ_ADDR, IRQ_ENABLE), 32'h1, 4'hf,
                 1'b0, 32'h0);
        add_step("irq enable read", 1'b0, dev_addr(IRQ_ADDR, IRQ_ENABLE), 32'h0, 4'hf,
                 1'b1, 32'h1);
        run_table();
        check("irq masked", 32'h0, o_irq);
        add_step("irq clear uart", 1'b1, dev_addr(IRQ_ADDR, IRQ_PENDING), 32'h2, 4'hf,
                 1'b0, 32'h0);
        add_step("irq pending clear", 1'b0, dev_addr(IRQ_ADDR, IRQ_PENDING), 32'h0, 4'hf,
                 1'b1, 32'h0);

        // Timer compare far in the future
        add_step("mtimecmp hi max", 1'b1, dev_addr(TIMER_ADDR, MTIMECMP_HI), 32'hffff_ffff,
                 4'hf, 1'b0, 32'h0);
        add_step("mtimecmp lo zero", 1'b1, dev_addr(TIMER_ADDR, MTIMECMP_LO), 32'h0, 4'hf,
                 1'b0, 32'h0);
        add_step("irq clear all", 1'b1, dev_addr(IRQ_ADDR, IRQ_PENDING), 32'h3, 4'hf,
                 1'b0, 32'h0);
        run_table();
        repeat (8) begin
            @(negedge ck);
            check("timer irq low", 32'h0, o_irq);
        end
        add_step("mtimecmp hi zero", 1'b1, dev_addr(TIMER_ADDR, MTIMECMP_HI), 32'h0, 4'hf,
                 1'b0, 32'h0);
        run_table();
        n = 0;
        while (!o_irq && n < WAIT_LIMIT) begin
            @(negedge ck);
            n++;
        end
        if (!o_irq) begin
            abort_run("Timer interrupt never reached o_irq");
        end

        bus_xfer(1'b0, dev_addr(TIMER_ADDR, MTIME_LO), 32'h0, 4'hf, t0);
        bus_xfer(1'b0, dev_addr(TIMER_ADDR, MTIME_LO), 32'h0, 4'hf, t1);
        check("mtime increases", 32'h1, {31'h0, t1 > t0});

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* flist.f */
rtl/soc_bus_pkg.sv
rtl/soc_periph_pkg.sv
rtl/dbus_decode.sv
rtl/gpio_reg.sv
rtl/mtimer.sv
rtl/uart_tx.sv
rtl/irq_reg.sv
rtl/periph_top.sv
tb/tb_periph_top.sv
